// ==== compile.f ====
+incdir+hw
hw/dns_rx_pkg.sv
hw/eth_hdr_rx.sv
hw/ipv4_hdr_rx.sv
hw/udp_port_filter.sv
hw/dns_hdr_rx.sv
hw/dns_rx_top.sv
verification/dns_rx_chk.sv
verification/dns_rx_tb.sv

// ==== hw/dns_hdr_rx.sv ====
// DNS header capture
`timescale 1ns/1ps
`include "dns_rx_defs.svh"

module dns_hdr_rx import dns_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  axis_beat_t in_beat,
    input  udp_meta_t  in_meta,
    output logic       in_ready,
    output logic       msg_valid,
    output dns_msg_t   msg,
    input  logic       msg_ready
);

    hdr_count_t cnt;
    logic       err_seen;
    logic       beat_ok;
    logic       hdr_full;
    logic       good;

    // pending message stalls the whole chain
    assign in_ready = !msg_valid;
    assign beat_ok  = in_valid && in_ready;
    // this beat completes the 12 bytes, or they are already in
    assign hdr_full = (cnt >= hdr_count_t'(`DNS_HDR_BYTES - 1));
    // error flag on the last beat counts too
    assign good = hdr_full && !err_seen && !in_beat.err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msg_valid <= 1'b0;
            cnt       <= '0;
            err_seen  <= 1'b0;
        end else begin
            if (msg_valid && msg_ready) begin
                msg_valid <= 1'b0;
            end
            // beat_ok only while msg_valid low, no clash with the clear
            if (beat_ok) begin
                if (in_beat.last) begin
                    cnt       <= '0;
                    err_seen  <= 1'b0;
                    // raised the cycle after the last beat
                    msg_valid <= good;
                end else begin
                    err_seen <= err_seen | in_beat.err;
                    // saturate, rest of frame just drains
                    if (cnt != hdr_count_t'(`DNS_HDR_BYTES)) begin
                        cnt <= cnt + 5'd1;
                    end
                end
            end
        end
    end

    // payload capture, frozen while msg_valid since no beats arrive
    always_ff @(posedge clk) begin
        if (beat_ok) begin
            // upstream meta is valid from the first beat on
            if (cnt == 5'd0) begin
                msg.udp <= in_meta;
            end
            case (cnt)
                5'd0, 5'd1: msg.id      <= {msg.id[7:0], in_beat.data};
                5'd2, 5'd3: msg.flags   <= {msg.flags[7:0], in_beat.data};
                5'd4, 5'd5: msg.qdcount <= {msg.qdcount[7:0], in_beat.data};
                5'd6, 5'd7: msg.ancount <= {msg.ancount[7:0], in_beat.data};
                // nscount and arcount only counted
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/dns_rx_defs.svh ====
// DNS receive constants
`ifndef DNS_RX_DEFS_SVH
`define DNS_RX_DEFS_SVH

// header lengths in bytes
`define ETH_HDR_BYTES 14
// options-free IPv4 header only
`define IP_HDR_BYTES 20
`define UDP_HDR_BYTES 8
// id, flags, qdcount, ancount, nscount, arcount
`define DNS_HDR_BYTES 12

// ethernet type for IPv4
`define ETHERTYPE_IPV4 16'h0800

// version nibble, upper half of IP byte 0
`define IP_VERSION_4 4'd4
// header length in 32-bit words, lower half of IP byte 0
`define IP_IHL_MIN 4'd5

// protocol field, IP byte 9
`define IP_PROTO_UDP 8'd17

// well known DNS server port
`define DNS_PORT 16'd53

`endif

// ==== hw/dns_rx_pkg.sv ====
// DNS receive types
package dns_rx_pkg;

    // plain vectors with a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ether_type_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] dns_word_t;
    // counts up to the 20 byte IP header
    typedef logic [4:0]  hdr_count_t;

    // one stream byte with its side flags
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  err;
    } axis_beat_t;

    // per-frame metadata, each layer wraps the one below
    typedef struct packed {
        mac_addr_t src_mac;
    } eth_meta_t;

    typedef struct packed {
        eth_meta_t  eth;
        ipv4_addr_t src_ip;
        ipv4_addr_t dst_ip;
    } ip_meta_t;

    typedef struct packed {
        ip_meta_t  ip;
        udp_port_t src_port;
    } udp_meta_t;

    // summary handed out per good DNS frame
    typedef struct packed {
        udp_meta_t udp;
        dns_word_t id;
        dns_word_t flags;
        dns_word_t qdcount;
        dns_word_t ancount;
    } dns_msg_t;

    // shared by the three header strippers
    typedef enum logic [1:0] {
        ST_HDR,
        ST_PAYLOAD,
        ST_DROP
    } hdr_state_t;

endpackage

// ==== hw/dns_rx_top.sv ====
// DNS receive sniffer top
`timescale 1ns/1ps

module dns_rx_top import dns_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_valid,
    input  axis_beat_t rx_beat,
    output logic       rx_ready,
    output logic       msg_valid,
    output dns_msg_t   msg,
    input  logic       msg_ready
);

    // ethernet payload, IP header first
    logic       eth_valid;
    logic       eth_ready;
    axis_beat_t eth_beat;
    eth_meta_t  eth_meta;

    // IP payload, UDP header first
    logic       ip_valid;
    logic       ip_ready;
    axis_beat_t ip_beat;
    ip_meta_t   ip_meta;

    // UDP payload to port 53, DNS header first
    logic       udp_valid;
    logic       udp_ready;
    axis_beat_t udp_beat;
    udp_meta_t  udp_meta;

    eth_hdr_rx i_eth_hdr_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rx_valid),
        .in_beat   (rx_beat),
        .in_ready  (rx_ready),
        .out_valid (eth_valid),
        .out_beat  (eth_beat),
        .out_meta  (eth_meta),
        .out_ready (eth_ready)
    );

    ipv4_hdr_rx i_ipv4_hdr_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (eth_valid),
        .in_beat   (eth_beat),
        .in_meta   (eth_meta),
        .in_ready  (eth_ready),
        .out_valid (ip_valid),
        .out_beat  (ip_beat),
        .out_meta  (ip_meta),
        .out_ready (ip_ready)
    );

    udp_port_filter i_udp_port_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ip_valid),
        .in_beat   (ip_beat),
        .in_meta   (ip_meta),
        .in_ready  (ip_ready),
        .out_valid (udp_valid),
        .out_beat  (udp_beat),
        .out_meta  (udp_meta),
        .out_ready (udp_ready)
    );

    // message handshake back-pressures everything above
    dns_hdr_rx i_dns_hdr_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (udp_valid),
        .in_beat   (udp_beat),
        .in_meta   (udp_meta),
        .in_ready  (udp_ready),
        .msg_valid (msg_valid),
        .msg       (msg),
        .msg_ready (msg_ready)
    );

endmodule

// ==== hw/eth_hdr_rx.sv ====
// Ethernet header stripper
`timescale 1ns/1ps
`include "dns_rx_defs.svh"

module eth_hdr_rx import dns_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  axis_beat_t in_beat,
    output logic       in_ready,
    output logic       out_valid,
    output axis_beat_t out_beat,
    output eth_meta_t  out_meta,
    input  logic       out_ready
);

    hdr_state_t  state;
    hdr_count_t  cnt;
    mac_addr_t   src_mac;
    byte_t       type_hi;
    ether_type_t frame_type;
    logic        beat_ok;
    logic        hdr_done;
    logic        hdr_err;

    // type only complete on byte 13, low byte straight off the bus
    assign frame_type = {type_hi, in_beat.data};
    assign beat_ok    = in_valid && in_ready;
    assign hdr_done   = (cnt == hdr_count_t'(`ETH_HDR_BYTES - 1));

    // payload is a zero-delay path, header and drop swallow bytes
    assign in_ready  = (state == ST_PAYLOAD) ? out_ready : 1'b1;
    assign out_valid = (state == ST_PAYLOAD) && in_valid;
    // header beat errors ride along on every payload beat
    assign out_beat.data = in_beat.data;
    assign out_beat.last = in_beat.last;
    assign out_beat.err  = in_beat.err | hdr_err;
    assign out_meta.src_mac = src_mac;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_HDR;
            cnt     <= '0;
            hdr_err <= 1'b0;
        end else if (beat_ok) begin
            // flag from any header byte, cleared with the frame
            if (in_beat.last) begin
                hdr_err <= 1'b0;
            end else if (state == ST_HDR) begin
                hdr_err <= hdr_err | in_beat.err;
            end
            case (state)
                ST_HDR: begin
                    if (in_beat.last) begin
                        // frame ended inside the header, nothing sent on
                        cnt <= '0;
                    end else if (hdr_done) begin
                        cnt   <= '0;
                        // one admit decision per frame
                        state <= (frame_type == `ETHERTYPE_IPV4) ? ST_PAYLOAD : ST_DROP;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                default: begin
                    // payload or drop, both end on last
                    if (in_beat.last) begin
                        state <= ST_HDR;
                    end
                end
            endcase
        end
    end

    // field capture, bytes 0-5 are the destination MAC and ignored
    always_ff @(posedge clk) begin
        if (beat_ok && state == ST_HDR) begin
            if (cnt >= 5'd6 && cnt <= 5'd11) begin
                src_mac <= {src_mac[39:0], in_beat.data};
            end
            if (cnt == 5'd12) begin
                type_hi <= in_beat.data;
            end
        end
    end

endmodule

// ==== hw/ipv4_hdr_rx.sv ====
// IPv4 header stripper
`timescale 1ns/1ps
`include "dns_rx_defs.svh"

module ipv4_hdr_rx import dns_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  axis_beat_t in_beat,
    input  eth_meta_t  in_meta,
    output logic       in_ready,
    output logic       out_valid,
    output axis_beat_t out_beat,
    output ip_meta_t   out_meta,
    input  logic       out_ready
);

    hdr_state_t state;
    hdr_count_t cnt;
    byte_t      ver_ihl;
    byte_t      proto;
    ipv4_addr_t src_ip;
    ipv4_addr_t dst_ip;
    logic       beat_ok;
    logic       hdr_done;
    logic       admit;
    logic       hdr_err;

    assign beat_ok  = in_valid && in_ready;
    assign hdr_done = (cnt == hdr_count_t'(`IP_HDR_BYTES - 1));
    // no options, so IHL must be exactly the minimum
    assign admit = (ver_ihl[7:4] == `IP_VERSION_4) &&
                   (ver_ihl[3:0] == `IP_IHL_MIN) &&
                   (proto == `IP_PROTO_UDP);

    assign in_ready  = (state == ST_PAYLOAD) ? out_ready : 1'b1;
    assign out_valid = (state == ST_PAYLOAD) && in_valid;
    // header beat errors ride along on every payload beat
    assign out_beat.data = in_beat.data;
    assign out_beat.last = in_beat.last;
    assign out_beat.err  = in_beat.err | hdr_err;
    // upstream stays in payload for this frame, its meta holds
    assign out_meta.eth    = in_meta;
    assign out_meta.src_ip = src_ip;
    assign out_meta.dst_ip = dst_ip;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_HDR;
            cnt     <= '0;
            hdr_err <= 1'b0;
        end else if (beat_ok) begin
            // flag from any header byte, cleared with the frame
            if (in_beat.last) begin
                hdr_err <= 1'b0;
            end else if (state == ST_HDR) begin
                hdr_err <= hdr_err | in_beat.err;
            end
            case (state)
                ST_HDR: begin
                    if (in_beat.last) begin
                        // truncated IP header
                        cnt <= '0;
                    end else if (hdr_done) begin
                        cnt   <= '0;
                        state <= admit ? ST_PAYLOAD : ST_DROP;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                default: begin
                    if (in_beat.last) begin
                        state <= ST_HDR;
                    end
                end
            endcase
        end
    end

    // length, id, frag, ttl and checksum bytes pass unread
    always_ff @(posedge clk) begin
        if (beat_ok && state == ST_HDR) begin
            if (cnt == 5'd0) begin
                ver_ihl <= in_beat.data;
            end
            if (cnt == 5'd9) begin
                proto <= in_beat.data;
            end
            if (cnt >= 5'd12 && cnt <= 5'd15) begin
                src_ip <= {src_ip[23:0], in_beat.data};
            end
            // last dst byte lands on the decision edge, not needed for it
            if (cnt >= 5'd16) begin
                dst_ip <= {dst_ip[23:0], in_beat.data};
            end
        end
    end

endmodule

// ==== hw/udp_port_filter.sv ====
// UDP DNS port filter
`timescale 1ns/1ps
`include "dns_rx_defs.svh"

module udp_port_filter import dns_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  axis_beat_t in_beat,
    input  ip_meta_t   in_meta,
    output logic       in_ready,
    output logic       out_valid,
    output axis_beat_t out_beat,
    output udp_meta_t  out_meta,
    input  logic       out_ready
);

    hdr_state_t state;
    hdr_count_t cnt;
    udp_port_t  src_port;
    byte_t      dst_hi;
    udp_port_t  dst_port;
    logic       beat_ok;
    logic       hdr_err;
    // port match held from byte 3 until the header ends
    logic       state_admit;

    // destination port completes on byte 3
    assign dst_port = {dst_hi, in_beat.data};
    assign beat_ok  = in_valid && in_ready;

    assign in_ready  = (state == ST_PAYLOAD) ? out_ready : 1'b1;
    assign out_valid = (state == ST_PAYLOAD) && in_valid;
    // header beat errors ride along on every payload beat
    assign out_beat.data = in_beat.data;
    assign out_beat.last = in_beat.last;
    assign out_beat.err  = in_beat.err | hdr_err;
    assign out_meta.ip       = in_meta;
    assign out_meta.src_port = src_port;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_HDR;
            cnt     <= '0;
            hdr_err <= 1'b0;
        end else if (beat_ok) begin
            // flag from any header byte, cleared with the frame
            if (in_beat.last) begin
                hdr_err <= 1'b0;
            end else if (state == ST_HDR) begin
                hdr_err <= hdr_err | in_beat.err;
            end
            case (state)
                ST_HDR: begin
                    if (in_beat.last) begin
                        cnt <= '0;
                    end else if (cnt == hdr_count_t'(`UDP_HDR_BYTES - 1)) begin
                        cnt <= '0;
                        // decision latched on byte 3, applied at header end
                        state <= (state_admit) ? ST_PAYLOAD : ST_DROP;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                default: begin
                    if (in_beat.last) begin
                        state <= ST_HDR;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ok && state == ST_HDR) begin
            if (cnt <= 5'd1) begin
                src_port <= {src_port[7:0], in_beat.data};
            end
            if (cnt == 5'd2) begin
                dst_hi <= in_beat.data;
            end
            if (cnt == 5'd3) begin
                state_admit <= (dst_port == `DNS_PORT);
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DNS sniffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f compile.f \
        --top-module dns_rx_tb -o dns_rx_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/dns_rx_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "testbench reported failure"
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "testbench ended without a result line"
    exit 1
fi
exit 0

// ==== verification/dns_rx_chk.sv ====
// DNS sniffer handshake checks
`timescale 1ns/1ps

module dns_rx_chk import dns_rx_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       rx_valid,
    input axis_beat_t rx_beat,
    input logic       rx_ready,
    input logic       msg_valid,
    input dns_msg_t   msg,
    input logic       msg_ready
);

    // held message must not move while stalled
    msg_stable: assert property (@(posedge clk) disable iff (!rst_n)
        msg_valid && !msg_ready |=> $stable(msg))
    else $error("msg changed while waiting for msg_ready");

    // reset leaves nothing pending
    msg_idle_after_reset: assert property (@(posedge clk)
        !rst_n |=> !msg_valid)
    else $error("msg_valid high in the cycle after reset");

    // a message only follows an accepted last beat
    msg_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(msg_valid) |-> $past(rx_valid && rx_ready && rx_beat.last))
    else $error("msg_valid rose without a last beat accepted the cycle before");

endmodule

bind dns_rx_top dns_rx_chk i_dns_rx_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_valid  (rx_valid),
    .rx_beat   (rx_beat),
    .rx_ready  (rx_ready),
    .msg_valid (msg_valid),
    .msg       (msg),
    .msg_ready (msg_ready)
);

// ==== verification/dns_rx_tb.sv ====
// DNS sniffer testbench
`timescale 1ns/1ps
`include "dns_rx_defs.svh"

module dns_rx_tb import dns_rx_pkg::*; ();

    localparam int NUM_TESTS       = 5;
    localparam int FRAMES_PER_TEST = 24;
    localparam int TOTAL_FRAMES    = NUM_TESTS * FRAMES_PER_TEST;
    // byte offsets of each layer within the frame
    localparam int IP_OFS  = `ETH_HDR_BYTES;
    localparam int UDP_OFS = IP_OFS + `IP_HDR_BYTES;
    localparam int DNS_OFS = UDP_OFS + `UDP_HDR_BYTES;
    // frame kinds
    localparam int K_GOOD  = 0;
    localparam int K_TYPE  = 1;
    localparam int K_VER   = 2;
    localparam int K_IHL   = 3;
    localparam int K_PROTO = 4;
    localparam int K_PORT  = 5;
    localparam int K_SHORT = 6;
    localparam int K_ERR   = 7;

    logic       clk;
    logic       rst_n;
    logic       rx_valid;
    axis_beat_t rx_beat;
    logic       rx_ready;
    logic       msg_valid;
    dns_msg_t   msg;
    logic       msg_ready;

    integer   seed = 32'h1df8;
    integer   ready_seed = 32'h1df8;
    byte_t    frame[$];
    logic     frame_err[$];
    dns_msg_t exp_q[$];
    dns_msg_t expected;
    bit       stall_mode = 1'b0;
    int       errors = 0;
    int       msg_count = 0;
    int       tests_passed = 0;
    int       tests_failed = 0;

    dns_rx_top i_dns_rx_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_valid  (rx_valid),
        .rx_beat   (rx_beat),
        .rx_ready  (rx_ready),
        .msg_valid (msg_valid),
        .msg       (msg),
        .msg_ready (msg_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int pick(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // big-endian field at a byte offset
    function automatic logic [15:0] word16(input int ofs);
        return {frame[ofs], frame[ofs + 1]};
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // good DNS query first, then spoil it by kind
    task automatic build_frame(input int kind);
        int len;
        int i;
        int nib;
        udp_port_t port;
        len = DNS_OFS + `DNS_HDR_BYTES + pick(40);
        frame.delete();
        frame_err.delete();
        for (i = 0; i < len; i++) begin
            frame.push_back(byte_t'(pick(256)));
            frame_err.push_back(1'b0);
        end
        frame[12] = 8'h08;
        frame[13] = 8'h00;
        frame[IP_OFS] = 8'h45;
        frame[IP_OFS + 9] = 8'd17;
        frame[UDP_OFS + 2] = 8'h00;
        frame[UDP_OFS + 3] = 8'd53;
        case (kind)
            K_TYPE: begin
                // ARP
                frame[13] = 8'h06;
            end
            K_VER: begin
                nib = pick(16);
                if (nib == 4) begin
                    nib = 6;
                end
                frame[IP_OFS] = {nib[3:0], 4'h5};
            end
            K_IHL: begin
                nib = 6 + pick(10);
                frame[IP_OFS] = {4'h4, nib[3:0]};
            end
            K_PROTO: begin
                // TCP or ICMP
                frame[IP_OFS + 9] = (pick(2) != 0) ? 8'd6 : 8'd1;
            end
            K_PORT: begin
                port = udp_port_t'(pick(65536));
                if (port == 16'd53) begin
                    port = 16'd54;
                end
                frame[UDP_OFS + 2] = port[15:8];
                frame[UDP_OFS + 3] = port[7:0];
            end
            K_SHORT: begin
                // cut anywhere before the 12th DNS byte
                len = 1 + pick(DNS_OFS + `DNS_HDR_BYTES - 1);
                while (frame.size() > len) begin
                    void'(frame.pop_back());
                    void'(frame_err.pop_back());
                end
            end
            K_ERR: begin
                // flag on any beat, headers included
                frame_err[pick(len)] = 1'b1;
            end
            default: ;
        endcase
    endtask

    // reference model, admit rules straight from the protocol fields
    function automatic bit predict(output dns_msg_t m);
        bit    ok;
        byte_t vi;
        int    i;
        m = '0;
        ok = (frame.size() >= DNS_OFS + `DNS_HDR_BYTES);
        for (i = 0; i < frame.size(); i++) begin
            if (frame_err[i]) begin
                ok = 1'b0;
            end
        end
        if (ok) begin
            vi = frame[IP_OFS];
            ok = (word16(12) == `ETHERTYPE_IPV4) &&
                 (vi[7:4] == `IP_VERSION_4) && (vi[3:0] == `IP_IHL_MIN) &&
                 (frame[IP_OFS + 9] == `IP_PROTO_UDP) &&
                 (word16(UDP_OFS + 2) == `DNS_PORT);
        end
        if (ok) begin
            m.udp.ip.eth.src_mac = {word16(6), word16(8), word16(10)};
            m.udp.ip.src_ip      = {word16(IP_OFS + 12), word16(IP_OFS + 14)};
            m.udp.ip.dst_ip      = {word16(IP_OFS + 16), word16(IP_OFS + 18)};
            m.udp.src_port       = word16(UDP_OFS);
            m.id      = word16(DNS_OFS);
            m.flags   = word16(DNS_OFS + 2);
            m.qdcount = word16(DNS_OFS + 4);
            m.ancount = word16(DNS_OFS + 6);
        end
        return ok;
    endfunction

    // one beat per accepted handshake, ready looked at mid-cycle
    task automatic send_frame();
        int i;
        bit taken;
        for (i = 0; i < frame.size(); i++) begin
            rx_valid     = 1'b1;
            rx_beat.data = frame[i];
            rx_beat.last = (i == frame.size() - 1);
            rx_beat.err  = frame_err[i];
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = rx_ready;
                @(posedge clk);
                #2;
            end
        end
        rx_valid = 1'b0;
        rx_beat  = '0;
    endtask

    function automatic int choose_kind(input int num);
        case (num)
            1: return K_GOOD;
            2: return (pick(2) != 0) ? K_GOOD : K_TYPE + pick(4);
            3: return (pick(2) != 0) ? K_GOOD : K_PORT;
            4: return (pick(2) != 0) ? K_GOOD : K_SHORT + pick(2);
            default: return (pick(2) != 0) ? K_GOOD : pick(8);
        endcase
    endfunction

    task automatic run_test(input int num, input string name);
        int       f;
        int       start_errors;
        int       start_msgs;
        int       wait_cycles;
        dns_msg_t m;
        start_errors = errors;
        start_msgs   = msg_count;
        stall_mode   = (num == 5);
        for (f = 0; f < FRAMES_PER_TEST; f++) begin
            build_frame(choose_kind(num));
            if (predict(m)) begin
                exp_q.push_back(m);
            end
            send_frame();
            idle_cycles(pick(4));
        end
        // drain, bounded
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 400) begin
            idle_cycles(1);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("test %0d: %0d expected messages never arrived", num, exp_q.size());
            exp_q.delete();
        end
        // room for a stray message to show
        idle_cycles(8);
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %0d %s: ok, %0d frames, %0d messages", num, name,
                     FRAMES_PER_TEST, msg_count - start_msgs);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - start_errors);
        end
    endtask

    // output side, sampled mid-cycle where the handshake is settled
    always @(negedge clk) begin
        if (rst_n && msg_valid && msg_ready) begin
            msg_count++;
            assert (exp_q.size() != 0)
            else begin
                errors++;
                $display("unexpected message at %0t with id %h", $time, msg.id);
            end
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                assert (msg.udp == expected.udp)
                else begin
                    errors++;
                    $display("FAIL %0t: message %0d addresses got %h expected %h",
                             $time, msg_count, msg.udp, expected.udp);
                end
                assert ({msg.id, msg.flags, msg.qdcount, msg.ancount} ==
                        {expected.id, expected.flags, expected.qdcount, expected.ancount})
                else begin
                    errors++;
                    $display("FAIL %0t: message %0d id %h flags %h qd %h an %h, expected id %h",
                             $time, msg_count, msg.id, msg.flags, msg.qdcount, msg.ancount,
                             expected.id);
                end
            end
        end
    end

    // consumer stalls, long low stretches and short high ones
    initial begin
        int stretch;
        stretch = 0;
        forever begin
            @(posedge clk);
            #2;
            if (!stall_mode) begin
                msg_ready = 1'b1;
            end else if (stretch > 0) begin
                stretch--;
            end else begin
                msg_ready = !msg_ready;
                stretch = msg_ready ? ($random(ready_seed) & 7) : ($random(ready_seed) & 31) + 8;
            end
        end
    end

    initial begin
        #(TOTAL_FRAMES * 120 * 4 * 20);
        $display("watchdog expired before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        rx_valid  = 1'b0;
        rx_beat   = '0;
        msg_ready = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle_cycles(2);
        // every stage idle in its header state
        assert (rx_ready)
        else begin
            errors++;
            $display("FAIL %0t: rx_ready low after reset", $time);
        end
        run_test(1, "valid frames");
        run_test(2, "bad eth and ip headers");
        run_test(3, "wrong udp port");
        run_test(4, "short and flagged frames");
        run_test(5, "mixed under back-pressure");
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
